//--- hdl/cache_pkg.sv
// shared constants and types for the data cache
// 32-bit words, word addressed memory side, byte offset ignored
// address layout is tag | index | word offset | byte offset
// geometry is fixed: 2 ways, 8 sets, 2 words per block

package cache_pkg;

	// datapath word and address width
	localparam int WORD_W = 32;

	// address fields
	localparam int TAG_W = 26;
	localparam int IDX_W = 3;
	localparam int BLK_W = 1; // word select inside a block
	localparam int BYT_W = 2; // dropped on lookup

	// cache geometry
	localparam int SETS = 8;
	localparam int WAYS = 2;

	// request queue entries
	localparam int REQ_DEPTH = 2;

	typedef logic [WORD_W-1:0] word_t;

	// dcache controller states
	typedef enum logic [3:0] {
		IDLE,    // waiting for a request or halt
		WB0,     // victim word 0 out to memory
		WB1,     // victim word 1
		FETCH0,  // new block word 0 in
		FETCH1,  // new block word 1
		RESP,    // read data held on the response port
		FLUSH0,  // flush sweep, word 0 of current block
		FLUSH1,  // flush sweep, word 1
		FLUSHED  // sweep done, parked until reset
	} cache_state_t;

endpackage

//--- hdl/cache_top.sv
// data cache top: request queue in front of the cache
// datapath side is valid/ready for requests and read responses
// memory side is a single word port stalled by mem_wait
// flushed rises once halt has written back every dirty block

`timescale 1ns/1ps

module cache_top (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              halt,
	output logic              flushed,
	// datapath requests
	input  logic              req_valid,
	input  logic              req_wen,
	input  cache_pkg::word_t  req_addr,
	input  cache_pkg::word_t  req_wdata,
	output logic              req_ready,
	// read responses
	output logic              rsp_valid,
	output cache_pkg::word_t  rsp_rdata,
	input  logic              rsp_ready,
	// memory
	output logic              mem_ren,
	output logic              mem_wen,
	output cache_pkg::word_t  mem_addr,
	output cache_pkg::word_t  mem_store,
	input  cache_pkg::word_t  mem_load,
	input  logic              mem_wait
);

	// queue head to cache
	logic              q_valid;
	logic              q_wen;
	cache_pkg::word_t  q_addr;
	cache_pkg::word_t  q_wdata;
	logic              q_ready;

	req_queue rq0 (
		.CLK       (CLK),
		.nRST      (nRST),
		.req_valid (req_valid),
		.req_wen   (req_wen),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_ready (req_ready),
		.q_valid   (q_valid),
		.q_wen     (q_wen),
		.q_addr    (q_addr),
		.q_wdata   (q_wdata),
		.q_ready   (q_ready)
	);

	dcache dc0 (
		.CLK       (CLK),
		.nRST      (nRST),
		.halt      (halt),
		.q_valid   (q_valid),
		.q_wen     (q_wen),
		.q_addr    (q_addr),
		.q_wdata   (q_wdata),
		.q_ready   (q_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_ready (rsp_ready),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_store (mem_store),
		.mem_load  (mem_load),
		.mem_wait  (mem_wait),
		.flushed   (flushed)
	);

endmodule

//--- hdl/dcache.sv
// two-way set associative write-back data cache, 8 sets of 2-word blocks
// one request at a time; only reads produce a response
// miss path: optional writeback of the dirty victim, then a 2-word fill
// memory port holds each access until mem_wait is low
// halt is taken only from IDLE, then every dirty block is written back
// flushed stays high until reset

`timescale 1ns/1ps

module dcache (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              halt,
	input  logic              q_valid,
	input  logic              q_wen,
	input  cache_pkg::word_t  q_addr,
	input  cache_pkg::word_t  q_wdata,
	output logic              q_ready,
	output logic              rsp_valid,
	output cache_pkg::word_t  rsp_rdata,
	input  logic              rsp_ready,
	output logic              mem_ren,
	output logic              mem_wen,
	output cache_pkg::word_t  mem_addr,
	output cache_pkg::word_t  mem_store,
	input  cache_pkg::word_t  mem_load,
	input  logic              mem_wait,
	output logic              flushed
);

	cache_pkg::cache_state_t state, next_state;

	// cache arrays, [way][set]
	logic [cache_pkg::TAG_W-1:0] tag_arr  [cache_pkg::WAYS][cache_pkg::SETS];
	cache_pkg::word_t data_arr [cache_pkg::WAYS][cache_pkg::SETS][2**cache_pkg::BLK_W];
	logic [cache_pkg::SETS-1:0]  valid_arr [cache_pkg::WAYS];
	logic [cache_pkg::SETS-1:0]  dirty_arr [cache_pkg::WAYS];
	logic [cache_pkg::SETS-1:0]  lru; // way to evict next

	// incoming request fields
	logic [cache_pkg::TAG_W-1:0] q_tag;
	logic [cache_pkg::IDX_W-1:0] q_idx;
	logic [cache_pkg::BLK_W-1:0] q_blk;
	logic hit0, hit1, hit, hit_way;
	logic vic_way, vic_dirty;
	logic accept, mem_done;

	// request in flight
	logic                        r_wen;
	logic [cache_pkg::TAG_W-1:0] r_tag;
	logic [cache_pkg::IDX_W-1:0] r_idx;
	logic [cache_pkg::BLK_W-1:0] r_blk;
	cache_pkg::word_t            r_wdata;
	logic                        r_way;

	// flush sweep position, way in the msb
	logic [cache_pkg::IDX_W:0]   fl_cnt;
	logic                        fl_way, fl_dirty, fl_last;
	logic [cache_pkg::IDX_W-1:0] fl_idx;

	logic [cache_pkg::BLK_W-1:0] word_sel;

	assign q_tag = q_addr[cache_pkg::WORD_W-1 -: cache_pkg::TAG_W];
	assign q_idx = q_addr[cache_pkg::BYT_W+cache_pkg::BLK_W +: cache_pkg::IDX_W];
	assign q_blk = q_addr[cache_pkg::BYT_W +: cache_pkg::BLK_W];

	assign hit0    = valid_arr[0][q_idx] && (tag_arr[0][q_idx] == q_tag);
	assign hit1    = valid_arr[1][q_idx] && (tag_arr[1][q_idx] == q_tag);
	assign hit     = hit0 || hit1;
	assign hit_way = hit1;

	// invalid way first, way 0 when both are empty, else lru
	assign vic_way   = !valid_arr[0][q_idx] ? 1'b0 :
	                   !valid_arr[1][q_idx] ? 1'b1 : lru[q_idx];
	assign vic_dirty = valid_arr[vic_way][q_idx] && dirty_arr[vic_way][q_idx];

	assign q_ready   = (state == cache_pkg::IDLE) && !halt;
	assign accept    = q_valid && q_ready;
	assign mem_done  = !mem_wait;
	assign rsp_valid = (state == cache_pkg::RESP);
	assign flushed   = (state == cache_pkg::FLUSHED);

	assign fl_way   = fl_cnt[cache_pkg::IDX_W];
	assign fl_idx   = fl_cnt[cache_pkg::IDX_W-1:0];
	assign fl_dirty = valid_arr[fl_way][fl_idx] && dirty_arr[fl_way][fl_idx];
	assign fl_last  = &fl_cnt;

	// second word of a block in these states
	assign word_sel = (state == cache_pkg::WB1) || (state == cache_pkg::FETCH1) ||
	                  (state == cache_pkg::FLUSH1);

	always_comb begin
		next_state = state;
		case (state)
			cache_pkg::IDLE: begin
				if (halt)
					next_state = cache_pkg::FLUSH0;
				else if (accept && !hit)
					next_state = vic_dirty ? cache_pkg::WB0 : cache_pkg::FETCH0;
				else if (accept && !q_wen)
					next_state = cache_pkg::RESP; // read hit
			end
			cache_pkg::WB0:    if (mem_done) next_state = cache_pkg::WB1;
			cache_pkg::WB1:    if (mem_done) next_state = cache_pkg::FETCH0;
			cache_pkg::FETCH0: if (mem_done) next_state = cache_pkg::FETCH1;
			cache_pkg::FETCH1: begin
				if (mem_done)
					next_state = r_wen ? cache_pkg::IDLE : cache_pkg::RESP;
			end
			cache_pkg::RESP:   if (rsp_ready) next_state = cache_pkg::IDLE;
			cache_pkg::FLUSH0: begin
				if (fl_dirty) begin
					if (mem_done)
						next_state = cache_pkg::FLUSH1;
				end else if (fl_last) begin
					next_state = cache_pkg::FLUSHED; // clean last block, nothing to write
				end
			end
			cache_pkg::FLUSH1: begin
				if (mem_done)
					next_state = fl_last ? cache_pkg::FLUSHED : cache_pkg::FLUSH0;
			end
			cache_pkg::FLUSHED: next_state = cache_pkg::FLUSHED;
			default:            next_state = cache_pkg::IDLE;
		endcase
	end

	// memory port
	always_comb begin
		mem_ren   = 1'b0;
		mem_wen   = 1'b0;
		mem_addr  = '0;
		mem_store = '0;
		case (state)
			cache_pkg::WB0, cache_pkg::WB1: begin
				mem_wen   = 1'b1;
				mem_addr  = {tag_arr[r_way][r_idx], r_idx, word_sel, {cache_pkg::BYT_W{1'b0}}};
				mem_store = data_arr[r_way][r_idx][word_sel];
			end
			cache_pkg::FETCH0, cache_pkg::FETCH1: begin
				mem_ren  = 1'b1;
				mem_addr = {r_tag, r_idx, word_sel, {cache_pkg::BYT_W{1'b0}}};
			end
			cache_pkg::FLUSH0, cache_pkg::FLUSH1: begin
				mem_wen   = fl_dirty; // clean blocks are skipped
				mem_addr  = {tag_arr[fl_way][fl_idx], fl_idx, word_sel, {cache_pkg::BYT_W{1'b0}}};
				mem_store = data_arr[fl_way][fl_idx][word_sel];
			end
			default: ;
		endcase
	end

	// control state and line status bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= cache_pkg::IDLE;
			valid_arr <= '{default: '0};
			dirty_arr <= '{default: '0};
			lru       <= '0;
			fl_cnt    <= '0;
		end else begin
			state <= next_state;
			if (accept && hit) begin
				lru[q_idx] <= ~hit_way;
				if (q_wen)
					dirty_arr[hit_way][q_idx] <= 1'b1;
			end
			if (state == cache_pkg::FETCH1 && mem_done) begin
				valid_arr[r_way][r_idx] <= 1'b1;
				dirty_arr[r_way][r_idx] <= r_wen; // write miss leaves it dirty
				lru[r_idx]              <= ~r_way;
			end
			if (state == cache_pkg::FLUSH0 && !fl_dirty && !fl_last)
				fl_cnt <= fl_cnt + 1'b1;
			if (state == cache_pkg::FLUSH1 && mem_done && !fl_last)
				fl_cnt <= fl_cnt + 1'b1;
		end
	end

	// tags, data, latched request and read data
	always_ff @(posedge CLK) begin
		if (accept) begin
			r_wen   <= q_wen;
			r_tag   <= q_tag;
			r_idx   <= q_idx;
			r_blk   <= q_blk;
			r_wdata <= q_wdata;
			r_way   <= vic_way;
			if (hit && q_wen)
				data_arr[hit_way][q_idx][q_blk] <= q_wdata;
			if (hit && !q_wen)
				rsp_rdata <= data_arr[hit_way][q_idx][q_blk];
		end
		if (state == cache_pkg::FETCH0 && mem_done)
			data_arr[r_way][r_idx][0] <= mem_load;
		if (state == cache_pkg::FETCH1 && mem_done) begin
			data_arr[r_way][r_idx][1] <= mem_load;
			tag_arr[r_way][r_idx]     <= r_tag;
			if (r_wen)
				data_arr[r_way][r_idx][r_blk] <= r_wdata; // merge over fetched word
			else
				rsp_rdata <= (r_blk == 1'b1) ? mem_load : data_arr[r_way][r_idx][0];
		end
	end

endmodule

//--- hdl/req_queue.sv
// request FIFO between datapath and dcache, REQ_DEPTH entries
// req_ready drops only when full and dcache is not popping,
// so a push and a pop can share a cycle on a full queue
// entries carry no reset, only pointers and count do

`timescale 1ns/1ps

module req_queue (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              req_valid,
	input  logic              req_wen,
	input  cache_pkg::word_t  req_addr,
	input  cache_pkg::word_t  req_wdata,
	output logic              req_ready,
	output logic              q_valid,
	output logic              q_wen,
	output cache_pkg::word_t  q_addr,
	output cache_pkg::word_t  q_wdata,
	input  logic              q_ready
);

	logic              wen_mem  [cache_pkg::REQ_DEPTH];
	cache_pkg::word_t  addr_mem [cache_pkg::REQ_DEPTH];
	cache_pkg::word_t  data_mem [cache_pkg::REQ_DEPTH];

	logic [$clog2(cache_pkg::REQ_DEPTH)-1:0]   wr_ptr, rd_ptr;
	logic [$clog2(cache_pkg::REQ_DEPTH+1)-1:0] count;
	logic push, pop;

	assign q_valid   = (count != 0);
	assign req_ready = (count != cache_pkg::REQ_DEPTH) || q_ready; // full but draining is ok
	assign push      = req_valid && req_ready;
	assign pop       = q_valid && q_ready;

	// head of queue
	assign q_wen   = wen_mem[rd_ptr];
	assign q_addr  = addr_mem[rd_ptr];
	assign q_wdata = data_mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (push) begin
			wen_mem[wr_ptr]  <= req_wen;
			addr_mem[wr_ptr] <= req_addr;
			data_mem[wr_ptr] <= req_wdata;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == cache_pkg::REQ_DEPTH-1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == cache_pkg::REQ_DEPTH-1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push+pop
			endcase
		end
	end

endmodule

//--- list.f
hdl/cache_pkg.sv
hdl/req_queue.sv
hdl/dcache.sv
hdl/cache_top.sv
test/mem_model.sv
test/tb_cache_top.sv

//--- test/mem_model.sv
// word memory behind the data cache, 1024 words, byte offset ignored
// addresses above 4 KB alias onto the same words
// each access stalls for wait_cycles cycles, change it only while idle
// completed writes go into a log of at most 512 entries

`timescale 1ns/1ps

module mem_model (
	input  logic              CLK,
	input  logic              nRST,
	input  logic [3:0]        wait_cycles,
	input  logic              mem_ren,
	input  logic              mem_wen,
	input  cache_pkg::word_t  mem_addr,
	input  cache_pkg::word_t  mem_store,
	output cache_pkg::word_t  mem_load,
	output logic              mem_wait
);

	cache_pkg::word_t mem      [1024];
	cache_pkg::word_t log_addr [512];
	cache_pkg::word_t log_data [512];
	int               log_cnt;
	logic [3:0]       stall; // cycles spent on the current access
	logic             busy;

	assign busy     = mem_ren || mem_wen;
	assign mem_wait = busy && (stall != wait_cycles);
	assign mem_load = mem[mem_addr[11:2]];

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			stall   <= '0;
			log_cnt <= 0;
		end else if (busy && mem_wait) begin
			stall <= stall + 1'b1;
		end else if (busy) begin
			stall <= '0; // access completes on this edge
			if (mem_wen && log_cnt < 512) begin
				mem[mem_addr[11:2]] <= mem_store;
				log_addr[log_cnt]   <= mem_addr;
				log_data[log_cnt]   <= mem_store;
				log_cnt             <= log_cnt + 1;
			end
		end
	end

endmodule

//--- test/tb_cache_top.sv
// directed tests for cache_top against a flat memory image and a shadow cache
// inputs change on the falling edge and outputs are sampled 10 ns before the rising edge
// test addresses stay below 4 KB so they fit the 1024 word memory model
// a watchdog bounds the run from the request count and the worst miss time

`timescale 1ns/1ps

module tb_cache_top;

	localparam int MAX_WAIT  = 3;
	localparam int N_REQ     = 32;
	localparam int REQ_CYC   = 4 * (MAX_WAIT + 1) + 4; // writeback plus fill plus response
	localparam int FLUSH_CYC = 2 * cache_pkg::SETS * cache_pkg::WAYS * (MAX_WAIT + 1);
	localparam int LIMIT     = 2 * (N_REQ * REQ_CYC + FLUSH_CYC + 100);

	logic CLK = 1'b0;
	logic nRST, halt, flushed;
	logic req_valid, req_wen, req_ready, rsp_valid, rsp_ready;
	logic mem_ren, mem_wen, mem_wait;
	logic [3:0] wait_cycles;
	cache_pkg::word_t req_addr, req_wdata, rsp_rdata, mem_addr, mem_store, mem_load;

	int errors = 0;
	int cyc = 0;
	int acc_cyc, rsp_cyc;
	logic saw_ren, saw_wen;
	logic [31:0] lfsr = 32'hbddc_4780;

	// reference model
	cache_pkg::word_t arch [1024]; // memory as the CPU should see it
	logic [cache_pkg::TAG_W-1:0] sh_tag [cache_pkg::WAYS][cache_pkg::SETS];
	logic sh_valid [cache_pkg::WAYS][cache_pkg::SETS];
	logic sh_dirty [cache_pkg::WAYS][cache_pkg::SETS];
	logic sh_lru   [cache_pkg::SETS];
	cache_pkg::word_t exp_rsp[$], exp_waddr[$], exp_wdata[$];

	cache_top dut0 (
		.CLK(CLK), .nRST(nRST), .halt(halt), .flushed(flushed),
		.req_valid(req_valid), .req_wen(req_wen), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_ready(rsp_ready),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_store(mem_store), .mem_load(mem_load), .mem_wait(mem_wait)
	);

	mem_model mem0 (
		.CLK(CLK), .nRST(nRST), .wait_cycles(wait_cycles),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_store(mem_store), .mem_load(mem_load), .mem_wait(mem_wait)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK)
		cyc <= cyc + 1;

	// response checker samples just before each rising edge
	always @(negedge CLK) begin
		#40;
		if (mem_ren)
			saw_ren = 1'b1;
		if (mem_wen)
			saw_wen = 1'b1;
		if (mem_ren && mem_wen) begin
			errors++;
			$display("mem_ren and mem_wen were both high at %0t", $time);
		end
		if (rsp_valid && rsp_ready) begin
			rsp_cyc = cyc;
			if (exp_rsp.size() == 0) begin
				errors++;
				$display("response %h arrived with no read outstanding at %0t", rsp_rdata, $time);
			end else begin
				check("rsp_rdata", exp_rsp.pop_front(), rsp_rdata);
			end
		end
	end

	initial begin
		#(LIMIT * 100);
		$display("timeout: tests did not finish within %0d cycles", LIMIT);
		$display("sim failed");
		$finish;
	end

	task automatic check(input string name, input cache_pkg::word_t exp,
	                     input cache_pkg::word_t act);
		if (exp !== act) begin
			errors++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic cache_pkg::word_t rand_word();
		cache_pkg::word_t w;
		w = '0;
		for (int i = 0; i < 32; i++)
			w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	function automatic cache_pkg::word_t addr_of(input int tag, input int idx, input int blk);
		return (cache_pkg::word_t'(tag) << (cache_pkg::IDX_W + cache_pkg::BLK_W + cache_pkg::BYT_W))
		     | (cache_pkg::word_t'(idx) << (cache_pkg::BLK_W + cache_pkg::BYT_W))
		     | (cache_pkg::word_t'(blk) << cache_pkg::BYT_W);
	endfunction

	// both words of a dirty block leave in word order
	task automatic expect_block(input logic [cache_pkg::TAG_W-1:0] tag,
	                            input logic [cache_pkg::IDX_W-1:0] idx);
		cache_pkg::word_t a;
		for (int b = 0; b < 2; b++) begin
			a = {tag, idx, (b == 1), {cache_pkg::BYT_W{1'b0}}};
			exp_waddr.push_back(a);
			exp_wdata.push_back(arch[a[11:2]]);
		end
	endtask

	task automatic model_access(input logic wen, input cache_pkg::word_t addr,
	                            input cache_pkg::word_t wdata);
		logic [cache_pkg::TAG_W-1:0] tag;
		logic [cache_pkg::IDX_W-1:0] idx;
		logic way;
		tag = addr[cache_pkg::WORD_W-1 -: cache_pkg::TAG_W];
		idx = addr[cache_pkg::BYT_W+cache_pkg::BLK_W +: cache_pkg::IDX_W];
		if (sh_valid[0][idx] && sh_tag[0][idx] == tag) begin
			way = 1'b0;
		end else if (sh_valid[1][idx] && sh_tag[1][idx] == tag) begin
			way = 1'b1;
		end else begin
			way = !sh_valid[0][idx] ? 1'b0 : !sh_valid[1][idx] ? 1'b1 : sh_lru[idx];
			if (sh_valid[way][idx] && sh_dirty[way][idx])
				expect_block(sh_tag[way][idx], idx);
			sh_valid[way][idx] = 1'b1;
			sh_tag[way][idx]   = tag;
			sh_dirty[way][idx] = 1'b0;
		end
		sh_lru[idx] = ~way; // other way is now least recent
		if (wen) begin
			sh_dirty[way][idx] = 1'b1;
			arch[addr[11:2]]   = wdata;
		end else begin
			exp_rsp.push_back(arch[addr[11:2]]);
		end
	endtask

	// starts on a falling edge and returns on the falling edge after acceptance
	task automatic send(input logic wen, input cache_pkg::word_t addr,
	                    input cache_pkg::word_t wdata);
		req_valid = 1'b1;
		req_wen   = wen;
		req_addr  = addr;
		req_wdata = wdata;
		#40;
		while (!req_ready) begin
			@(negedge CLK);
			#40;
		end
		acc_cyc = cyc;
		model_access(wen, addr, wdata);
		@(negedge CLK);
		req_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_rsp.size() != 0)
			@(negedge CLK);
	endtask

	task automatic check_writes();
		check("write log count", exp_waddr.size(), mem0.log_cnt);
		for (int i = 0; i < exp_waddr.size() && i < mem0.log_cnt; i++) begin
			check("write log addr", exp_waddr[i], mem0.log_addr[i]);
			check("write log data", exp_wdata[i], mem0.log_data[i]);
		end
	endtask

	task automatic test_read_hit();
		wait_cycles = 4'd2;
		send(1'b0, addr_of(5, 0, 0), '0); // cold miss
		drain();
		saw_ren = 1'b0;
		send(1'b0, addr_of(5, 0, 1), '0);
		drain();
		check("hit latency", 2, rsp_cyc - acc_cyc);
		check("mem_ren on hit", 0, saw_ren);
	endtask

	task automatic test_write_back();
		saw_wen = 1'b0;
		send(1'b1, addr_of(5, 0, 0), rand_word());
		send(1'b0, addr_of(5, 0, 0), '0);
		drain();
		check("mem_wen on write hit", 0, saw_wen);
	endtask

	task automatic test_lru_evict();
		int n0;
		wait_cycles = 4'd3;
		n0 = mem0.log_cnt;
		send(1'b1, addr_of(1, 2, 1), rand_word());
		send(1'b1, addr_of(2, 2, 0), rand_word());
		send(1'b0, addr_of(3, 2, 0), '0); // tag 1 is lru and dirty
		drain();
		check("evicted block", addr_of(1, 2, 0), mem0.log_addr[n0]);
		send(1'b0, addr_of(1, 2, 1), '0);
		send(1'b0, addr_of(2, 2, 0), '0);
		send(1'b0, addr_of(3, 2, 1), '0);
		drain();
		check_writes();
	endtask

	task automatic test_backpressure();
		rsp_ready = 1'b0;
		send(1'b0, addr_of(5, 0, 0), '0);
		send(1'b0, addr_of(5, 0, 1), '0);
		send(1'b0, addr_of(3, 2, 1), '0);
		repeat (3) begin
			#40;
			check("req_ready when full", 0, req_ready);
			@(negedge CLK);
		end
		rsp_ready = 1'b1;
		send(1'b0, addr_of(2, 2, 0), '0);
		send(1'b0, addr_of(5, 0, 1), '0);
		drain();
	endtask

	task automatic test_flush();
		wait_cycles = 4'd1;
		for (int s = 4; s < 7; s++) begin
			send(1'b1, addr_of(10, s, lfsr_bit()), rand_word());
			send(1'b1, addr_of(11, s, lfsr_bit()), rand_word());
		end
		send(1'b0, addr_of(10, 4, 0), '0); // its response means the writes are done
		drain();
		for (int w = 0; w < cache_pkg::WAYS; w++)
			for (int s = 0; s < cache_pkg::SETS; s++)
				if (sh_valid[w][s] && sh_dirty[w][s])
					expect_block(sh_tag[w][s], s);
		saw_ren   = 1'b0;
		halt      = 1'b1;
		req_valid = 1'b1; // stray read that must never be served
		req_wen   = 1'b0;
		req_addr  = addr_of(20, 1, 0);
		@(negedge CLK);
		req_valid = 1'b0;
		while (!flushed)
			@(negedge CLK);
		repeat (4) @(negedge CLK);
		check("flushed", 1, flushed);
		check("mem_ren after halt", 0, saw_ren);
		check_writes();
		for (int i = 0; i < 1024; i++)
			check("memory image", arch[i], mem0.mem[i]);
	endtask

	initial begin
		nRST        = 1'b0;
		halt        = 1'b0;
		req_valid   = 1'b0;
		req_wen     = 1'b0;
		req_addr    = '0;
		req_wdata   = '0;
		rsp_ready   = 1'b1;
		wait_cycles = 4'd2;
		saw_ren     = 1'b0;
		saw_wen     = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			arch[i]     = rand_word();
			mem0.mem[i] = arch[i];
		end
		for (int s = 0; s < cache_pkg::SETS; s++) begin
			sh_lru[s] = 1'b0;
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				sh_valid[w][s] = 1'b0;
				sh_dirty[w][s] = 1'b0;
				sh_tag[w][s]   = '0;
			end
		end
		repeat (5) @(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);
		test_read_hit();
		test_write_back();
		test_lru_evict();
		test_backpressure();
		test_flush();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
